//--- common/vsp_pkg.sv
// vsp pipeline shared definitions
// Widths, RISC-V encodings, ALU codes and the two views of an instruction word
`default_nettype none

package vsp_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;
    localparam int alu_op_w  = 3;

    // ALU operation codes
    localparam logic [alu_op_w-1:0] alu_add = 3'd0;
    localparam logic [alu_op_w-1:0] alu_sub = 3'd1;
    localparam logic [alu_op_w-1:0] alu_xor = 3'd2;
    localparam logic [alu_op_w-1:0] alu_or  = 3'd3;
    localparam logic [alu_op_w-1:0] alu_and = 3'd4;
    localparam logic [alu_op_w-1:0] alu_slt = 3'd5;

    ////////////////////////////////////////
    // RISC-V encodings
    ////////////////////////////////////////

    // Major opcodes that execute
    localparam logic [6:0] opcode_op     = 7'b0110011;
    localparam logic [6:0] opcode_op_imm = 7'b0010011;

    // funct3 values shared by register and immediate forms
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    // funct7, alternate form only selects SUB here
    localparam logic [6:0] funct7_base = 7'b0000000;
    localparam logic [6:0] funct7_alt  = 7'b0100000;

    // Fetch address sequence
    localparam logic [xlen-1:0] pc_reset = 32'h0000_0000;
    localparam logic [xlen-1:0] pc_step  = 32'd4;

    // One instruction word, R-type and I-type views of the same bits
    typedef union packed {
        struct packed {
            logic [6:0]           funct7;
            logic [reg_idx_w-1:0] rs2;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [reg_idx_w-1:0] rd;
            logic [6:0]           opcode;
        } r;
        struct packed {
            logic [11:0]          imm;
            logic [reg_idx_w-1:0] rs1;
            logic [2:0]           funct3;
            logic [reg_idx_w-1:0] rd;
            logic [6:0]           opcode;
        } i;
    } inst_word_t;

endpackage

`default_nettype wire

//--- logic/vsp_regfile.sv
// vsp register file
// 32 x 32-bit, x0 reads zero, reads see a same-cycle write
`timescale 1ns/100ps
`default_nettype none

module vsp_regfile (
    input  wire                            clock,
    input  wire                            reset,
    input  wire  [vsp_pkg::reg_idx_w-1:0]  rd_idx_a,
    input  wire  [vsp_pkg::reg_idx_w-1:0]  rd_idx_b,
    input  wire                            wr_en,
    input  wire  [vsp_pkg::reg_idx_w-1:0]  wr_idx,
    input  wire  [vsp_pkg::xlen-1:0]       wr_data,
    output logic [vsp_pkg::xlen-1:0]       rd_data_a,
    output logic [vsp_pkg::xlen-1:0]       rd_data_b
);
    import vsp_pkg::*;

    logic [xlen-1:0] regs [2**reg_idx_w];
    logic            wr_live;

    // x0 is never written
    assign wr_live = wr_en && (wr_idx != '0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_idx_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Write-through so a reader two words behind the producer gets the new value
    assign rd_data_a = (wr_live && wr_idx == rd_idx_a) ? wr_data : regs[rd_idx_a];
    assign rd_data_b = (wr_live && wr_idx == rd_idx_b) ? wr_data : regs[rd_idx_b];

endmodule

`default_nettype wire

//--- logic/vsp_fetch.sv
// vsp fetch stage
// PC, memory read request and the fetch/dispatch pipeline register
`timescale 1ns/100ps
`default_nettype none

module vsp_fetch (
    input  wire                       clock,
    input  wire                       reset,
    input  wire                       mem_valid,
    input  wire vsp_pkg::inst_word_t  mem_data,
    output logic                      mem_command,
    output logic [vsp_pkg::xlen-1:0]  mem_addr,
    output logic                      if_valid,
    output logic [vsp_pkg::xlen-1:0]  if_pc,
    output vsp_pkg::inst_word_t       if_inst
);
    import vsp_pkg::*;

    logic [xlen-1:0] pc;
    logic            req_active;
    logic            accept;

    ////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////

    // Held low through reset, then a read is pending every cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            req_active <= 1'b0;
        end else begin
            req_active <= 1'b1;
        end
    end

    assign mem_command = req_active;
    // Address is the PC, which only moves on acceptance
    assign mem_addr    = pc;

    // Word taken at the edge where the response meets the request
    assign accept = req_active && mem_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= pc_reset;
        end else if (accept) begin
            pc <= pc + pc_step;
        end
    end

    ////////////////////////////////////////
    // Fetch/dispatch register
    ////////////////////////////////////////

    // Valid for exactly one cycle per accepted word
    always_ff @(posedge clock) begin
        if (reset) begin
            if_valid <= 1'b0;
        end else begin
            if_valid <= accept;
        end
    end

    // Payload
    always_ff @(posedge clock) begin
        if (accept) begin
            if_pc   <= pc;
            if_inst <= mem_data;
        end
    end

endmodule

`default_nettype wire

//--- logic/vsp_dispatch.sv
// vsp dispatch stage
// Decodes the fetched word, reads operands and loads the dispatch/execute register
`timescale 1ns/100ps
`default_nettype none

module vsp_dispatch (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             if_valid,
    input  wire  [vsp_pkg::xlen-1:0]        if_pc,
    input  wire  vsp_pkg::inst_word_t       if_inst,
    input  wire                             wr_en,
    input  wire  [vsp_pkg::reg_idx_w-1:0]   wr_idx,
    input  wire  [vsp_pkg::xlen-1:0]        wr_data,
    output logic                            ex_valid,
    output logic [vsp_pkg::xlen-1:0]        ex_pc,
    output logic [vsp_pkg::alu_op_w-1:0]    ex_op,
    output logic [vsp_pkg::xlen-1:0]        ex_rs1_val,
    output logic [vsp_pkg::xlen-1:0]        ex_opb_val,
    output logic                            ex_use_imm,
    output logic [vsp_pkg::reg_idx_w-1:0]   ex_rs1,
    output logic [vsp_pkg::reg_idx_w-1:0]   ex_rs2,
    output logic                            ex_wr_en,
    output logic [vsp_pkg::reg_idx_w-1:0]   ex_rd
);
    import vsp_pkg::*;

    logic [alu_op_w-1:0] f3_op;
    logic                f3_ok;
    logic [alu_op_w-1:0] dec_op;
    logic                dec_ok;
    logic                dec_use_imm;
    logic [xlen-1:0]     imm_sext;
    logic [xlen-1:0]     rs1_val;
    logic [xlen-1:0]     rs2_val;

    ////////////////////////////////////////
    // Decode
    ////////////////////////////////////////

    // funct3 picks the operation for both R and I forms
    always_comb begin
        f3_ok = 1'b1;
        case (if_inst.r.funct3)
            funct3_add_sub: f3_op = alu_add;
            funct3_slt:     f3_op = alu_slt;
            funct3_xor:     f3_op = alu_xor;
            funct3_or:      f3_op = alu_or;
            funct3_and:     f3_op = alu_and;
            default: begin
                f3_op = alu_add;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_op      = f3_op;
        dec_ok      = 1'b0;
        dec_use_imm = 1'b0;
        if (if_inst.r.opcode == opcode_op) begin
            // R-type, funct7 must be clean except for SUB
            if (if_inst.r.funct7 == funct7_base) begin
                dec_ok = f3_ok;
            end else if (if_inst.r.funct7 == funct7_alt
                         && if_inst.r.funct3 == funct3_add_sub) begin
                dec_ok = 1'b1;
                dec_op = alu_sub;
            end
        end else if (if_inst.i.opcode == opcode_op_imm) begin
            dec_ok      = f3_ok;
            dec_use_imm = 1'b1;
        end
    end

    // I-type immediate, sign extended
    assign imm_sext = {{(xlen-12){if_inst.i.imm[11]}}, if_inst.i.imm};

    vsp_regfile u_vsp_regfile (
        .clock     (clock),
        .reset     (reset),
        .rd_idx_a  (if_inst.i.rs1),
        .rd_idx_b  (if_inst.r.rs2),
        .wr_en     (wr_en),
        .wr_idx    (wr_idx),
        .wr_data   (wr_data),
        .rd_data_a (rs1_val),
        .rd_data_b (rs2_val)
    );

    ////////////////////////////////////////
    // Dispatch/execute register
    ////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_valid <= 1'b0;
            ex_wr_en <= 1'b0;
        end else begin
            ex_valid <= if_valid;
            // Unsupported words and rd of x0 retire without a write
            ex_wr_en <= if_valid && dec_ok && (if_inst.r.rd != '0);
        end
    end

    always_ff @(posedge clock) begin
        ex_pc      <= if_pc;
        ex_op      <= dec_op;
        ex_rs1_val <= rs1_val;
        ex_opb_val <= dec_use_imm ? imm_sext : rs2_val;
        ex_use_imm <= dec_use_imm;
        ex_rs1     <= if_inst.r.rs1;
        ex_rs2     <= if_inst.r.rs2;
        ex_rd      <= if_inst.r.rd;
    end

endmodule

`default_nettype wire

//--- logic/vsp_execute.sv
// vsp execute stage
// Operand forwarding from the commit register, ALU, and the commit register
`timescale 1ns/100ps
`default_nettype none

module vsp_execute (
    input  wire                             clock,
    input  wire                             reset,
    input  wire                             ex_valid,
    input  wire  [vsp_pkg::xlen-1:0]        ex_pc,
    input  wire  [vsp_pkg::alu_op_w-1:0]    ex_op,
    input  wire  [vsp_pkg::xlen-1:0]        ex_rs1_val,
    input  wire  [vsp_pkg::xlen-1:0]        ex_opb_val,
    input  wire                             ex_use_imm,
    input  wire  [vsp_pkg::reg_idx_w-1:0]   ex_rs1,
    input  wire  [vsp_pkg::reg_idx_w-1:0]   ex_rs2,
    input  wire                             ex_wr_en,
    input  wire  [vsp_pkg::reg_idx_w-1:0]   ex_rd,
    output logic                            commit_valid,
    output logic [vsp_pkg::xlen-1:0]        commit_pc,
    output logic                            commit_wr_en,
    output logic [vsp_pkg::reg_idx_w-1:0]   commit_rd,
    output logic [vsp_pkg::xlen-1:0]        commit_data
);
    import vsp_pkg::*;

    logic            fwd_a;
    logic            fwd_b;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;

    ////////////////////////////////////////
    // Forwarding
    ////////////////////////////////////////

    // Producer one word ahead sits in the commit register, not yet in the regfile
    assign fwd_a = commit_valid && commit_wr_en && (commit_rd == ex_rs1);
    // Immediate forms carry no rs2
    assign fwd_b = commit_valid && commit_wr_en && !ex_use_imm && (commit_rd == ex_rs2);

    assign op_a = fwd_a ? commit_data : ex_rs1_val;
    assign op_b = fwd_b ? commit_data : ex_opb_val;

    ////////////////////////////////////////
    // ALU
    ////////////////////////////////////////

    always_comb begin
        case (ex_op)
            alu_add: alu_result = op_a + op_b;
            alu_sub: alu_result = op_a - op_b;
            alu_xor: alu_result = op_a ^ op_b;
            alu_or:  alu_result = op_a | op_b;
            alu_and: alu_result = op_a & op_b;
            // Signed compare
            alu_slt: alu_result = {{(xlen-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
            default: alu_result = op_a + op_b;
        endcase
    end

    // Commit register
    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid <= 1'b0;
            commit_wr_en <= 1'b0;
        end else begin
            commit_valid <= ex_valid;
            commit_wr_en <= ex_valid && ex_wr_en;
        end
    end

    always_ff @(posedge clock) begin
        commit_pc   <= ex_pc;
        commit_rd   <= ex_rd;
        commit_data <= alu_result;
    end

endmodule

`default_nettype wire

//--- logic/vsp_cpu.sv
// vsp CPU top level
// Fetch, dispatch and execute stages joined to the memory port and commit outputs
`timescale 1ns/100ps
`default_nettype none

module vsp_cpu (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            mem_valid,
    input  wire  [vsp_pkg::xlen-1:0]       mem_data,
    output logic                           mem_command,
    output logic [vsp_pkg::xlen-1:0]       mem_addr,
    output logic                           commit_valid,
    output logic [vsp_pkg::xlen-1:0]       commit_pc,
    output logic                           commit_wr_en,
    output logic [vsp_pkg::reg_idx_w-1:0]  commit_rd,
    output logic [vsp_pkg::xlen-1:0]       commit_data
);
    import vsp_pkg::*;

    ////////////////////////////////////////
    // Stage wires
    ////////////////////////////////////////

    // Fetch to dispatch
    logic                 if_valid;
    logic [xlen-1:0]      if_pc;
    inst_word_t           if_inst;

    // Dispatch to execute
    logic                 ex_valid;
    logic [xlen-1:0]      ex_pc;
    logic [alu_op_w-1:0]  ex_op;
    logic [xlen-1:0]      ex_rs1_val;
    logic [xlen-1:0]      ex_opb_val;
    logic                 ex_use_imm;
    logic [reg_idx_w-1:0] ex_rs1;
    logic [reg_idx_w-1:0] ex_rs2;
    logic                 ex_wr_en;
    logic [reg_idx_w-1:0] ex_rd;

    vsp_fetch u_vsp_fetch (
        .clock       (clock),
        .reset       (reset),
        .mem_valid   (mem_valid),
        .mem_data    (mem_data),
        .mem_command (mem_command),
        .mem_addr    (mem_addr),
        .if_valid    (if_valid),
        .if_pc       (if_pc),
        .if_inst     (if_inst)
    );

    // Register file write port fed straight from the commit register
    vsp_dispatch u_vsp_dispatch (
        .clock      (clock),
        .reset      (reset),
        .if_valid   (if_valid),
        .if_pc      (if_pc),
        .if_inst    (if_inst),
        .wr_en      (commit_wr_en),
        .wr_idx     (commit_rd),
        .wr_data    (commit_data),
        .ex_valid   (ex_valid),
        .ex_pc      (ex_pc),
        .ex_op      (ex_op),
        .ex_rs1_val (ex_rs1_val),
        .ex_opb_val (ex_opb_val),
        .ex_use_imm (ex_use_imm),
        .ex_rs1     (ex_rs1),
        .ex_rs2     (ex_rs2),
        .ex_wr_en   (ex_wr_en),
        .ex_rd      (ex_rd)
    );

    vsp_execute u_vsp_execute (
        .clock        (clock),
        .reset        (reset),
        .ex_valid     (ex_valid),
        .ex_pc        (ex_pc),
        .ex_op        (ex_op),
        .ex_rs1_val   (ex_rs1_val),
        .ex_opb_val   (ex_opb_val),
        .ex_use_imm   (ex_use_imm),
        .ex_rs1       (ex_rs1),
        .ex_rs2       (ex_rs2),
        .ex_wr_en     (ex_wr_en),
        .ex_rd        (ex_rd),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_wr_en (commit_wr_en),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

endmodule

`default_nettype wire

//--- tests/vsp_cpu_chk.sv
// vsp CPU protocol checker
// Memory request stability, commit timing and commit packet rules
`timescale 1ns/100ps
`default_nettype none

module vsp_cpu_chk (
    input  wire                            clock,
    input  wire                            reset,
    input  wire                            mem_command,
    input  wire                            mem_valid,
    input  wire  [vsp_pkg::xlen-1:0]       mem_addr,
    input  wire                            commit_valid,
    input  wire                            commit_wr_en,
    input  wire  [vsp_pkg::reg_idx_w-1:0]  commit_rd
);

    ////////////////////////////////////////
    // Reset
    ////////////////////////////////////////

    // No request and no commit out of a reset cycle
    a_no_cmd_in_reset: assert property (@(posedge clock) $past(reset) |-> !mem_command)
        else $error("mem_command high after a reset cycle");
    a_no_commit_in_reset: assert property (@(posedge clock) $past(reset) |-> !commit_valid)
        else $error("commit_valid high after a reset cycle");

    ////////////////////////////////////////
    // Memory port
    ////////////////////////////////////////

    // Pending request keeps command and address until mem_valid
    a_addr_stable: assert property (@(posedge clock) disable iff (reset)
        $past(mem_command && !mem_valid) |-> mem_command && mem_addr == $past(mem_addr))
        else $error("mem_addr or mem_command changed before acceptance");

    ////////////////////////////////////////
    // Commit
    ////////////////////////////////////////

    // Commit register loads at the second edge after acceptance
    // so its valid bit is first sampled at the third, both ways
    a_commit_after_accept: assert property (@(posedge clock) disable iff (reset)
        $past(mem_command && mem_valid, 3) |-> commit_valid)
        else $error("Accepted word did not commit two cycles later");
    a_commit_has_accept: assert property (@(posedge clock) disable iff (reset)
        commit_valid |-> $past(mem_command && mem_valid, 3))
        else $error("Commit without an acceptance two cycles before");

    // A write is always a valid commit to a real register
    a_wr_en_rules: assert property (@(posedge clock) disable iff (reset)
        commit_wr_en |-> commit_valid && commit_rd != '0)
        else $error("commit_wr_en without commit_valid or with rd of x0");

endmodule

`default_nettype wire

//--- tests/vsp_cpu_tb.sv
// vsp CPU testbench
// Random program, memory with random latency, ISA model and commit checking
`timescale 1ns/100ps
`default_nettype none

module vsp_cpu_tb;
    import vsp_pkg::*;

    localparam int prog_len   = 200;
    localparam int max_cycles = prog_len * 6 + 100;

    logic                 clock;
    logic                 reset;
    logic                 mem_valid;
    logic [xlen-1:0]      mem_data;
    logic                 mem_command;
    logic [xlen-1:0]      mem_addr;
    logic                 commit_valid;
    logic [xlen-1:0]      commit_pc;
    logic                 commit_wr_en;
    logic [reg_idx_w-1:0] commit_rd;
    logic [xlen-1:0]      commit_data;

    logic [31:0] program_words [prog_len];
    logic [31:0] model_regs [32];
    logic [31:0] model_pc;

    // Expected commits, oldest first
    logic [31:0] exp_pc [$];
    logic        exp_wr_en [$];
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          exp_cycle [$];

    // Memory model
    logic        req_busy;
    logic [31:0] req_addr;
    int          req_wait;

    int cycle;
    int commits;
    int errors;

    vsp_cpu u_vsp_cpu (
        .clock        (clock),
        .reset        (reset),
        .mem_valid    (mem_valid),
        .mem_data     (mem_data),
        .mem_command  (mem_command),
        .mem_addr     (mem_addr),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_wr_en (commit_wr_en),
        .commit_rd    (commit_rd),
        .commit_data  (commit_data)
    );

    bind vsp_cpu vsp_cpu_chk u_vsp_cpu_chk (
        .clock        (clock),
        .reset        (reset),
        .mem_command  (mem_command),
        .mem_valid    (mem_valid),
        .mem_addr     (mem_addr),
        .commit_valid (commit_valid),
        .commit_wr_en (commit_wr_en),
        .commit_rd    (commit_rd)
    );

    initial clock = 1'b0;
    always #4 clock = ~clock;

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERR %s got %h expected %h", name, got, expected);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Program and memory
    ////////////////////////////////////////

    task automatic build_program();
        logic [2:0]  f3_set [5];
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        int          kind;
        f3_set = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
        for (int i = 0; i < prog_len; i++) begin
            kind = $urandom % 10;
            // Few registers so dependencies and x0 come up often
            rd  = 5'($urandom % 8);
            rs1 = 5'($urandom % 8);
            rs2 = 5'($urandom % 8);
            f3  = f3_set[$urandom % 5];
            imm = 12'($urandom);
            if (kind < 4) begin
                f7 = (f3 == 3'b000 && $urandom % 2 == 1) ? 7'h20 : 7'h00;
                program_words[i] = {f7, rs2, rs1, f3, rd, 7'h33};
            end else if (kind < 8) begin
                program_words[i] = {imm, rs1, f3, rd, 7'h13};
            end else if (kind == 8) begin
                // Register form with a bad funct7
                program_words[i] = {7'h01, rs2, rs1, f3, rd, 7'h33};
            end else begin
                program_words[i] = $urandom;
            end
        end
    endtask

    // Zero past the end of the program
    function automatic logic [31:0] memory_word(input logic [31:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog_len) begin
            return program_words[idx];
        end else begin
            return 32'h0;
        end
    endfunction

    ////////////////////////////////////////
    // ISA model
    ////////////////////////////////////////

    task automatic model_execute(input logic [31:0] word);
        logic [6:0]  opcode;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [4:0]  rd;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] result;
        logic        known;
        opcode = word[6:0];
        rd     = word[11:7];
        f3     = word[14:12];
        f7     = word[31:25];
        a      = model_regs[word[19:15]];
        b      = 32'h0;
        result = 32'h0;
        known  = 1'b0;
        if (opcode == 7'h33 && (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000))) begin
            b     = model_regs[word[24:20]];
            known = 1'b1;
        end else if (opcode == 7'h13) begin
            // Sign-extended 12-bit immediate
            b     = {{20{word[31]}}, word[31:20]};
            known = 1'b1;
        end
        if (known) begin
            case (f3)
                3'b000:  result = (opcode == 7'h33 && f7 == 7'h20) ? a - b : a + b;
                3'b010:  result = ($signed(a) < $signed(b)) ? 32'h1 : 32'h0;
                3'b100:  result = a ^ b;
                3'b110:  result = a | b;
                3'b111:  result = a & b;
                default: known = 1'b0;
            endcase
        end
        // x0 stays zero
        known = known && (rd != 5'd0);
        if (known) begin
            model_regs[rd] = result;
        end
        exp_pc.push_back(model_pc);
        exp_wr_en.push_back(known);
        exp_rd.push_back(rd);
        exp_data.push_back(result);
        exp_cycle.push_back(cycle + 2);
        model_pc = model_pc + pc_step;
    endtask

    ////////////////////////////////////////
    // Per-cycle work, on the falling edge
    ////////////////////////////////////////

    task automatic step_memory();
        if (req_busy && mem_valid) begin
            // Taken at the last rising edge
            model_execute(memory_word(req_addr));
            req_busy = 1'b0;
        end
        mem_valid = 1'b0;
        mem_data  = $urandom;
        if (mem_command) begin
            if (req_busy) begin
                compare_value("mem_addr", mem_addr, req_addr);
            end else begin
                // New request at the next program address
                compare_value("mem_addr", mem_addr, model_pc);
                req_busy = 1'b1;
                req_addr = mem_addr;
                req_wait = $urandom % 4;
            end
            if (req_wait == 0) begin
                mem_valid = 1'b1;
                mem_data  = memory_word(req_addr);
            end else begin
                req_wait--;
            end
        end
    endtask

    task automatic check_commit();
        logic [31:0] pc;
        logic        wr_en;
        logic [4:0]  rd;
        logic [31:0] data;
        int          due;
        if (commit_valid && exp_pc.size() == 0) begin
            $display("Commit at pc %h with no accepted instruction behind it", commit_pc);
            errors++;
        end else if (commit_valid) begin
            pc    = exp_pc.pop_front();
            wr_en = exp_wr_en.pop_front();
            rd    = exp_rd.pop_front();
            data  = exp_data.pop_front();
            due   = exp_cycle.pop_front();
            compare_value("commit_pc", commit_pc, pc);
            compare_value("commit_wr_en", 32'(commit_wr_en), 32'(wr_en));
            compare_value("commit_rd", 32'(commit_rd), 32'(rd));
            // Data only means something on a write
            if (wr_en) begin
                compare_value("commit_data", commit_data, data);
            end
            if (cycle != due) begin
                $display("Commit of pc %h in cycle %0d, expected in cycle %0d", pc, cycle, due);
                errors++;
            end
            commits++;
        end else if (exp_cycle.size() > 0 && exp_cycle[0] <= cycle) begin
            $display("No commit in cycle %0d for the word at pc %h", cycle, exp_pc[0]);
            errors++;
            void'(exp_pc.pop_front());
            void'(exp_wr_en.pop_front());
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            void'(exp_cycle.pop_front());
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        int seed_ret;
        seed_ret  = $urandom(32'haa38_1707);
        reset     = 1'b1;
        mem_valid = 1'b0;
        mem_data  = 32'h0;
        req_busy  = 1'b0;
        req_addr  = 32'h0;
        req_wait  = 0;
        cycle     = 0;
        commits   = 0;
        errors    = 0;
        model_pc  = pc_reset;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = 32'h0;
        end
        build_program();

        repeat (5) @(negedge clock);
        reset = 1'b0;
        // Pipeline empty straight out of reset
        compare_value("commit_valid", 32'(commit_valid), 32'h0);

        while (commits < prog_len && cycle < max_cycles) begin
            @(negedge clock);
            cycle++;
            step_memory();
            check_commit();
        end
        if (commits < prog_len) begin
            $display("Timeout after %0d cycles with %0d of %0d commits",
                     cycle, commits, prog_len);
            errors++;
        end

        $display("Errors: %0d, commits: %0d of %0d", errors, commits, prog_len);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
common/vsp_pkg.sv
logic/vsp_regfile.sv
logic/vsp_fetch.sv
logic/vsp_dispatch.sv
logic/vsp_execute.sv
logic/vsp_cpu.sv
tests/vsp_cpu_chk.sv
tests/vsp_cpu_tb.sv

//--- Makefile
# Verilator build and run of the vsp CPU testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module vsp_cpu_tb -f verilog.f -Mdir obj_dir
	@out="$$(./obj_dir/Vvsp_cpu_tb)"; echo "$$out"; echo "$$out" | grep -q '^Test OK$$'

clean:
	rm -rf obj_dir
